/* common/gat_pkg.sv */
package gat_pkg;

  // Bus types
  typedef logic [7:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // Datapath types
  typedef logic [3:0]         node_t;
  typedef logic signed [7:0]  feat_t;
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [7:0]  val_t;
  typedef logic signed [31:0] acc_t;

  // Issue v/r, gather v/r, act v/r from the top bit down
  typedef logic [5:0] dbg_flags_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    DONE
  } ctrl_state_e;

  localparam int NUM_NODES = 2 ** $bits(node_t);

  // Register map
  localparam wb_addr_t REG_CTRL        = 8'h00;
  localparam wb_addr_t REG_WEIGHT      = 8'h01;
  localparam wb_addr_t REG_ENTRY       = 8'h02;
  localparam wb_addr_t FEAT_BASE       = 8'h10;
  localparam wb_addr_t RESULT_BASE     = 8'h20;
  localparam wb_addr_t REG_DBG_FLAGS   = 8'h30;
  localparam wb_addr_t REG_DBG_COUNT   = 8'h31;
  localparam wb_addr_t REG_DBG_CAPTURE = 8'h32;

endpackage

/* common/stage_if.sv */
`timescale 1ns/1ps

interface stage_if;
  import gat_pkg::*;

  logic  valid;
  logic  ready;
  node_t row;
  acc_t  data;

  modport source (
    output valid,
    output row,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  row,
    input  data,
    output ready
  );

  modport monitor (
    input valid,
    input ready,
    input row,
    input data
  );

endinterface

/* rtl/gat_ctrl.sv */
`timescale 1ns/1ps

module gat_ctrl #(
  parameter int MAX_ENTRIES = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  gat_pkg::wb_addr_t wb_adr_i,
  input  gat_pkg::wb_data_t wb_dat_i,
  output logic              wb_ack_o,
  output gat_pkg::wb_data_t wb_dat_o,
  output gat_pkg::weight_t  weight_o,
  output logic              start_o,
  output logic              feat_we_o,
  output gat_pkg::node_t    feat_addr_o,
  output gat_pkg::feat_t    feat_wdata_o,
  input  gat_pkg::feat_t    feat_rdata_i,
  output gat_pkg::node_t    result_addr_o,
  input  gat_pkg::acc_t     result_rdata_i,
  output logic [1:0]        dbg_sel_o,
  input  gat_pkg::wb_data_t dbg_rdata_i,
  input  logic              pipe_idle_i,
  stage_if.source           issue_link
);
  import gat_pkg::*;

  localparam int CNT_W = $clog2(MAX_ENTRIES + 1);
  localparam int IDX_W = $clog2(MAX_ENTRIES);

  ctrl_state_e      state_q;
  logic [CNT_W-1:0] entry_cnt_q;
  logic [CNT_W-1:0] issue_ptr_q;
  logic             list_stale_q;
  logic             start_q;
  weight_t          weight_q;
  logic             access;
  logic             wr_access;
  logic             busy;
  logic             done;
  logic             push_ok;
  logic [IDX_W-1:0] push_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             issue_fire;
  wb_data_t         rdata;

  node_t row_mem [MAX_ENTRIES];
  node_t col_mem [MAX_ENTRIES];
  val_t  val_mem [MAX_ENTRIES];

  assign access    = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_access = access && wb_we_i;
  assign busy      = (state_q == ISSUE) || (state_q == DRAIN);
  assign done      = (state_q == DONE);
  assign start_o   = start_q;
  assign weight_o  = weight_q;

  // Feature, result and debug ports follow the bus address
  assign feat_we_o     = wr_access && (wb_adr_i[7:4] == FEAT_BASE[7:4]);
  assign feat_addr_o   = wb_adr_i[3:0];
  assign feat_wdata_o  = feat_t'(wb_dat_i[7:0]);
  assign result_addr_o = wb_adr_i[3:0];
  assign dbg_sel_o     = wb_adr_i[1:0];

  // A stale list restarts at slot zero
  assign push_ok  = wr_access && (wb_adr_i == REG_ENTRY) && !busy &&
                    (list_stale_q || (entry_cnt_q != CNT_W'(MAX_ENTRIES)));
  assign push_idx = list_stale_q ? '0 : entry_cnt_q[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      row_mem[push_idx] <= wb_dat_i[23:20];
      col_mem[push_idx] <= wb_dat_i[19:16];
      val_mem[push_idx] <= val_t'(wb_dat_i[7:0]);
    end
  end

  // Entry layout on the link mirrors the register layout
  assign rd_idx          = issue_ptr_q[IDX_W-1:0];
  assign issue_link.valid = (state_q == ISSUE) && (issue_ptr_q != entry_cnt_q);
  assign issue_link.row  = row_mem[rd_idx];
  assign issue_link.data = {12'd0, col_mem[rd_idx], 8'd0, val_mem[rd_idx]};
  assign issue_fire      = issue_link.valid && issue_link.ready;

  always_comb begin
    rdata = '0;
    if (wb_adr_i == REG_CTRL) begin
      rdata = {30'd0, done, busy};
    end else if (wb_adr_i == REG_WEIGHT) begin
      rdata = {24'd0, weight_q};
    end else if (wb_adr_i == REG_ENTRY) begin
      rdata = wb_data_t'(entry_cnt_q);
    end else if (wb_adr_i[7:4] == FEAT_BASE[7:4]) begin
      rdata = {24'd0, feat_rdata_i};
    end else if (wb_adr_i[7:4] == RESULT_BASE[7:4]) begin
      rdata = result_rdata_i;
    end else if ((wb_adr_i >= REG_DBG_FLAGS) && (wb_adr_i <= REG_DBG_CAPTURE)) begin
      rdata = dbg_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      wb_ack_o     <= 1'b0;
      wb_dat_o     <= '0;
      start_q      <= 1'b0;
      weight_q     <= '0;
      entry_cnt_q  <= '0;
      issue_ptr_q  <= '0;
      list_stale_q <= 1'b0;
    end else begin
      wb_ack_o <= access;
      if (access && !wb_we_i) begin
        wb_dat_o <= rdata;
      end
      start_q <= wr_access && (wb_adr_i == REG_CTRL) && wb_dat_i[0] && !busy;
      if (wr_access && (wb_adr_i == REG_WEIGHT)) begin
        weight_q <= weight_t'(wb_dat_i[7:0]);
      end
      if (push_ok) begin
        entry_cnt_q  <= list_stale_q ? CNT_W'(1) : entry_cnt_q + 1'b1;
        list_stale_q <= 1'b0;
      end

      case (state_q)
        IDLE, DONE: begin
          if (start_q) begin
            state_q     <= ISSUE;
            issue_ptr_q <= '0;
            // No new pushes since the last run means an empty list
            if (list_stale_q) begin
              entry_cnt_q  <= '0;
              list_stale_q <= 1'b0;
            end
          end
        end
        ISSUE: begin
          if (issue_fire) begin
            issue_ptr_q <= issue_ptr_q + 1'b1;
          end else if (issue_ptr_q == entry_cnt_q) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (pipe_idle_i) begin
            state_q      <= DONE;
            list_stale_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/spmm_unit.sv */
`timescale 1ns/1ps

module spmm_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           feat_we_i,
  input  gat_pkg::node_t feat_addr_i,
  input  gat_pkg::feat_t feat_wdata_i,
  output gat_pkg::feat_t feat_rdata_o,
  stage_if.sink          issue_link,
  stage_if.source        gather_link
);
  import gat_pkg::*;

  feat_t feat_mem [NUM_NODES];

  logic  out_valid_q;
  node_t out_row_q;
  acc_t  out_data_q;
  node_t col;
  val_t  val;
  feat_t feat;
  logic  take;

  always_ff @(posedge clk) begin
    if (feat_we_i) begin
      feat_mem[feat_addr_i] <= feat_wdata_i;
    end
  end

  assign feat_rdata_o = feat_mem[feat_addr_i];

  // Column and value unpacked from the entry word
  assign col  = issue_link.data[19:16];
  assign val  = val_t'(issue_link.data[7:0]);
  assign feat = feat_mem[col];

  // Accept when empty or emptying this cycle
  assign issue_link.ready = !out_valid_q || gather_link.ready;
  assign take             = issue_link.valid && issue_link.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
    end else if (gather_link.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_row_q  <= issue_link.row;
      out_data_q <= acc_t'(val) * acc_t'(feat);
    end
  end

  assign gather_link.valid = out_valid_q;
  assign gather_link.row   = out_row_q;
  assign gather_link.data  = out_data_q;

endmodule

/* rtl/weight_act_unit.sv */
`timescale 1ns/1ps

module weight_act_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  gat_pkg::weight_t weight_i,
  stage_if.sink            gather_link,
  stage_if.source          act_link
);
  import gat_pkg::*;

  logic  out_valid_q;
  node_t out_row_q;
  acc_t  out_data_q;
  acc_t  prod;
  acc_t  act;
  logic  take;

  assign prod = gather_link.data * acc_t'(weight_i);

  // Leaky style activation, negative side scaled by a quarter
  assign act = prod[31] ? (prod >>> 2) : prod;

  assign gather_link.ready = !out_valid_q || act_link.ready;
  assign take              = gather_link.valid && gather_link.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
    end else if (act_link.ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_row_q  <= gather_link.row;
      out_data_q <= act;
    end
  end

  assign act_link.valid = out_valid_q;
  assign act_link.row   = out_row_q;
  assign act_link.data  = out_data_q;

endmodule

/* rtl/aggr_unit.sv */
`timescale 1ns/1ps

module aggr_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  gat_pkg::node_t rd_addr_i,
  output gat_pkg::acc_t  rd_data_o,
  output logic           idle_o,
  stage_if.sink          act_link
);
  import gat_pkg::*;

  acc_t acc_mem [NUM_NODES];

  logic  wr_pending_q;
  node_t wr_row_q;
  acc_t  wr_sum_q;
  logic  take;

  // Ready drops for the write-back cycle
  assign act_link.ready = !wr_pending_q;
  assign take           = act_link.valid && act_link.ready;
  assign idle_o         = !wr_pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_pending_q <= 1'b0;
    end else begin
      wr_pending_q <= take;
    end
  end

  // Read phase
  always_ff @(posedge clk) begin
    if (take) begin
      wr_row_q <= act_link.row;
      wr_sum_q <= acc_mem[act_link.row] + act_link.data;
    end
  end

  // Write phase, or clear of all rows on start
  always_ff @(posedge clk) begin
    if (start_i) begin
      for (int i = 0; i < NUM_NODES; i++) begin
        acc_mem[i] <= '0;
      end
    end else if (wr_pending_q) begin
      acc_mem[wr_row_q] <= wr_sum_q;
    end
  end

  assign rd_data_o = acc_mem[rd_addr_i];

endmodule

/* rtl/debug_monitor.sv */
`timescale 1ns/1ps

module debug_monitor #(
  parameter int CAPTURE_IDX = 5
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear_i,
  input  logic [1:0]        sel_i,
  output gat_pkg::wb_data_t rdata_o,
  stage_if.monitor          issue_link,
  stage_if.monitor          gather_link,
  stage_if.monitor          act_link
);
  import gat_pkg::*;

  dbg_flags_t flags_q;
  dbg_flags_t seen;
  logic       armed_q;
  wb_data_t   act_cnt_q;
  wb_data_t   gather_cnt_q;
  wb_data_t   capture_q;
  logic       gather_fire;
  logic       act_fire;

  assign seen = {issue_link.valid, issue_link.ready,
                 gather_link.valid, gather_link.ready,
                 act_link.valid, act_link.ready};

  assign gather_fire = gather_link.valid && gather_link.ready;
  assign act_fire    = act_link.valid && act_link.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q      <= 1'b0;
      flags_q      <= '0;
      act_cnt_q    <= '0;
      gather_cnt_q <= '0;
      capture_q    <= '0;
    end else if (clear_i) begin
      armed_q      <= 1'b1;
      flags_q      <= '0;
      act_cnt_q    <= '0;
      gather_cnt_q <= '0;
      capture_q    <= '0;
    end else begin
      // Idle readies are high out of reset, so flags wait for a start
      if (armed_q) begin
        flags_q <= flags_q | seen;
      end
      if (act_fire) begin
        act_cnt_q <= act_cnt_q + 1'b1;
      end
      if (gather_fire) begin
        gather_cnt_q <= gather_cnt_q + 1'b1;
        if (gather_cnt_q == wb_data_t'(CAPTURE_IDX)) begin
          capture_q <= gather_link.data;
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (sel_i == REG_DBG_FLAGS[1:0]) begin
      rdata_o = wb_data_t'(flags_q);
    end else if (sel_i == REG_DBG_COUNT[1:0]) begin
      rdata_o = act_cnt_q;
    end else if (sel_i == REG_DBG_CAPTURE[1:0]) begin
      rdata_o = capture_q;
    end
  end

endmodule

/* rtl/gat_engine.sv */
`timescale 1ns/1ps

module gat_engine #(
  parameter int MAX_ENTRIES = 32,
  parameter int CAPTURE_IDX = 5
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  gat_pkg::wb_addr_t wb_adr_i,
  input  gat_pkg::wb_data_t wb_dat_i,
  output logic              wb_ack_o,
  output gat_pkg::wb_data_t wb_dat_o
);
  import gat_pkg::*;

  weight_t    weight;
  logic       start;
  logic       feat_we;
  node_t      feat_addr;
  feat_t      feat_wdata;
  feat_t      feat_rdata;
  node_t      result_addr;
  acc_t       result_rdata;
  logic [1:0] dbg_sel;
  wb_data_t   dbg_rdata;
  logic       aggr_idle;
  logic       pipe_idle;

  stage_if issue_link ();
  stage_if gather_link ();
  stage_if act_link ();

  // Drained once both register stages and the accumulator are empty
  assign pipe_idle = aggr_idle && !gather_link.valid && !act_link.valid;

  gat_ctrl #(
    .MAX_ENTRIES (MAX_ENTRIES)
  ) u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .weight_o       (weight),
    .start_o        (start),
    .feat_we_o      (feat_we),
    .feat_addr_o    (feat_addr),
    .feat_wdata_o   (feat_wdata),
    .feat_rdata_i   (feat_rdata),
    .result_addr_o  (result_addr),
    .result_rdata_i (result_rdata),
    .dbg_sel_o      (dbg_sel),
    .dbg_rdata_i    (dbg_rdata),
    .pipe_idle_i    (pipe_idle),
    .issue_link     (issue_link.source)
  );

  spmm_unit u_spmm (
    .clk          (clk),
    .rst_n        (rst_n),
    .feat_we_i    (feat_we),
    .feat_addr_i  (feat_addr),
    .feat_wdata_i (feat_wdata),
    .feat_rdata_o (feat_rdata),
    .issue_link   (issue_link.sink),
    .gather_link  (gather_link.source)
  );

  weight_act_unit u_weight_act (
    .clk         (clk),
    .rst_n       (rst_n),
    .weight_i    (weight),
    .gather_link (gather_link.sink),
    .act_link    (act_link.source)
  );

  aggr_unit u_aggr (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (start),
    .rd_addr_i (result_addr),
    .rd_data_o (result_rdata),
    .idle_o    (aggr_idle),
    .act_link  (act_link.sink)
  );

  debug_monitor #(
    .CAPTURE_IDX (CAPTURE_IDX)
  ) u_debug (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (start),
    .sel_i       (dbg_sel),
    .rdata_o     (dbg_rdata),
    .issue_link  (issue_link.monitor),
    .gather_link (gather_link.monitor),
    .act_link    (act_link.monitor)
  );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 50,
  parameter int RESET_CYCLES   = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* verification/gat_tb.sv */
`timescale 1ns/1ps

module gat_tb;
  import gat_pkg::*;

  localparam int MAX_ENTRIES  = 32;
  localparam int CAPTURE_IDX  = 5;
  localparam int ACK_TIMEOUT  = 20;
  localparam int DONE_POLLS   = 200;
  localparam int RST_TIMEOUT  = 20;

  logic     clk;
  logic     rst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  logic     wb_ack;
  wb_data_t wb_dat_r;

  integer  seed;
  int      n_checks;
  int      err_value;
  int      err_timeout;
  int      n_entries;
  weight_t weight;
  feat_t   feats [NUM_NODES];
  node_t   e_row [MAX_ENTRIES + 4];
  node_t   e_col [MAX_ENTRIES + 4];
  val_t    e_val [MAX_ENTRIES + 4];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_engine #(
    .MAX_ENTRIES (MAX_ENTRIES),
    .CAPTURE_IDX (CAPTURE_IDX)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_ack_o (wb_ack),
    .wb_dat_o (wb_dat_r)
  );

  // Expected row sum with negative terms scaled by a quarter
  function automatic acc_t expected_row(input node_t r);
    acc_t sum;
    acc_t p;
    sum = '0;
    for (int i = 0; i < n_entries; i++) begin
      if (e_row[i] == r) begin
        p = acc_t'(e_val[i]) * acc_t'(feats[e_col[i]]) * acc_t'(weight);
        if (p < 0) begin
          p = p >>> 2;
        end
        sum = sum + p;
      end
    end
    return sum;
  endfunction

  task automatic check_word(input string name, input wb_data_t exp, input wb_data_t got);
    n_checks++;
    if (got !== exp) begin
      err_value++;
      $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  task automatic check_acc(input string name, input acc_t exp, input acc_t got);
    n_checks++;
    if (got !== exp) begin
      err_value++;
      $display("Fail t=%0t %s expected %0d actual %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_flags(input string name, input dbg_flags_t exp, input dbg_flags_t got);
    n_checks++;
    if (got !== exp) begin
      err_value++;
      $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, got);
    end
  endtask

  task automatic wb_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                           output wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= addr;
    wb_dat_w <= wdata;
    // Ack is sampled mid-cycle, away from the clock edge
    @(negedge clk);
    while (!wb_ack && waited < ACK_TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      err_timeout++;
      $display("Timeout at t=%0t: no ack for bus access to address %h", $time, addr);
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
    wb_access(1'b0, addr, '0, data);
  endtask

  task automatic wait_done();
    wb_data_t d;
    int       polls;
    polls = 0;
    wb_read(REG_CTRL, d);
    while (!d[1] && polls < DONE_POLLS) begin
      polls++;
      wb_read(REG_CTRL, d);
    end
    if (!d[1]) begin
      err_timeout++;
      $display("Timeout at t=%0t: run never reached done", $time);
    end else begin
      check_word("ctrl after run", 32'h2, d);
    end
  endtask

  task automatic program_features();
    for (int i = 0; i < NUM_NODES; i++) begin
      feats[i] = feat_t'($random(seed));
      wb_write(wb_addr_t'(FEAT_BASE + i), {24'd0, feats[i]});
    end
  endtask

  task automatic make_entries(input int count);
    for (int i = 0; i < count; i++) begin
      e_row[i] = node_t'($random(seed));
      // Every few entries repeat the previous row back to back
      if (i % 4 == 1) begin
        e_row[i] = e_row[i - 1];
      end
      e_col[i] = node_t'($random(seed));
      e_val[i] = val_t'($random(seed));
    end
  endtask

  task automatic push_entries(input int count);
    for (int i = 0; i < count; i++) begin
      wb_write(REG_ENTRY, {8'd0, e_row[i], e_col[i], 8'd0, e_val[i]});
    end
  endtask

  task automatic check_results();
    wb_data_t d;
    for (int r = 0; r < NUM_NODES; r++) begin
      wb_read(wb_addr_t'(RESULT_BASE + r), d);
      check_acc($sformatf("result[%0d]", r), expected_row(node_t'(r)), acc_t'(d));
    end
  endtask

  initial begin
    wb_data_t d;
    int       waited;
    seed        = 32'h6cf33b88;
    n_checks    = 0;
    err_value   = 0;
    err_timeout = 0;
    n_entries   = 0;
    weight      = '0;
    waited      = 0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;

    while (rst_n !== 1'b1 && waited < RST_TIMEOUT) begin
      waited++;
      @(posedge clk);
    end
    if (rst_n !== 1'b1) begin
      err_timeout++;
      $display("Timeout: reset was never released");
    end

    // Reset state
    wb_read(REG_CTRL, d);
    check_word("ctrl", 32'h0, d);
    wb_read(REG_DBG_FLAGS, d);
    check_flags("dbg_flags", 6'h00, dbg_flags_t'(d[5:0]));
    wb_read(REG_DBG_COUNT, d);
    check_word("dbg_count", 32'h0, d);
    wb_read(REG_DBG_CAPTURE, d);
    check_word("dbg_capture", 32'h0, d);

    // Register readback
    weight = 8'sd5;
    wb_write(REG_WEIGHT, {24'd0, weight});
    program_features();
    wb_read(REG_WEIGHT, d);
    check_word("weight", {24'd0, weight}, d);
    for (int i = 0; i < NUM_NODES; i++) begin
      wb_read(wb_addr_t'(FEAT_BASE + i), d);
      check_word($sformatf("feat[%0d]", i), {24'd0, feats[i]}, d);
    end

    // Positive weight with 20 entries
    n_entries = 20;
    make_entries(n_entries);
    push_entries(n_entries);
    wb_read(REG_ENTRY, d);
    check_word("entry_count", wb_data_t'(n_entries), d);
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    check_results();
    wb_read(REG_DBG_FLAGS, d);
    check_flags("dbg_flags", 6'h3f, dbg_flags_t'(d[5:0]));
    wb_read(REG_DBG_COUNT, d);
    check_word("dbg_count", wb_data_t'(n_entries), d);
    wb_read(REG_DBG_CAPTURE, d);
    check_word("dbg_capture",
               wb_data_t'(acc_t'(e_val[CAPTURE_IDX]) * acc_t'(feats[e_col[CAPTURE_IDX]])), d);

    // Negative weight exercises the shift on both product signs
    weight = -8'sd7;
    wb_write(REG_WEIGHT, {24'd0, weight});
    n_entries = 12;
    make_entries(n_entries);
    push_entries(n_entries);
    wb_write(REG_CTRL, 32'h1);
    // Push into a list that still has room while the run is busy
    wb_write(REG_ENTRY, {8'd0, 4'h3, 4'h3, 8'd0, 8'h11});
    wb_read(REG_ENTRY, d);
    check_word("entry_count while busy", wb_data_t'(n_entries), d);
    wait_done();
    check_results();

    // Overflow of the entry buffer and a start while busy
    n_entries = MAX_ENTRIES;
    make_entries(MAX_ENTRIES + 3);
    push_entries(MAX_ENTRIES + 3);
    wb_read(REG_ENTRY, d);
    check_word("entry_count", wb_data_t'(MAX_ENTRIES), d);
    wb_write(REG_CTRL, 32'h1);
    wb_read(REG_CTRL, d);
    check_word("ctrl while busy", 32'h1, d);
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    check_results();
    wb_read(REG_DBG_COUNT, d);
    check_word("dbg_count", wb_data_t'(MAX_ENTRIES), d);

    // Start with no new entries
    n_entries = 0;
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    wb_read(REG_ENTRY, d);
    check_word("entry_count", 32'h0, d);
    check_results();
    wb_read(REG_DBG_COUNT, d);
    check_word("dbg_count", 32'h0, d);
    wb_read(REG_DBG_CAPTURE, d);
    check_word("dbg_capture", 32'h0, d);

    $display("Summary: %0d checks, %0d value errors, %0d timeouts",
             n_checks, err_value, err_timeout);
    if (err_value == 0 && err_timeout == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* gat_engine.f */
common/gat_pkg.sv
common/stage_if.sv
rtl/gat_ctrl.sv
rtl/spmm_unit.sv
rtl/weight_act_unit.sv
rtl/aggr_unit.sv
rtl/debug_monitor.sv
rtl/gat_engine.sv
verification/tb_clk_gen.sv
verification/gat_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module gat_tb -f gat_engine.f -o gat_sim \
  || { echo "Compile failed"; exit 1; }

./obj_dir/gat_sim > sim.log 2>&1
cat sim.log

grep -qx '>>> PASS' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
